// ==== include/mem_hier_settings.svh ====
`ifndef MEM_HIER_SETTINGS_SVH
`define MEM_HIER_SETTINGS_SVH

// cpu word and cache block
`define MH_WORD_W   16  // bits per word
`define MH_BLOCK_W  64  // bits per block, four words

// word address split, tag | index | offset
`define MH_OFFSET_W 2   // word within block
`define MH_INDEX_W  6   // 64 lines per cache
`define MH_TAG_W    8   // upper address bits

// backing store timing
`define MH_MEM_LAT  4   // cycles per block transfer

`endif

// ==== hw/mem_hier_pkg.sv ====
`default_nettype none
`include "mem_hier_settings.svh"

package mem_hier_pkg;

  localparam int WORDS_PER_BLK = `MH_BLOCK_W / `MH_WORD_W;  // 4 words per block

  typedef logic [`MH_WORD_W-1:0] word_t;               // one cpu word
  typedef word_t [WORDS_PER_BLK-1:0] block_t;          // block indexed by word offset

  typedef struct packed {
    logic [`MH_TAG_W-1:0]    tag;     // compared against stored tag
    logic [`MH_INDEX_W-1:0]  index;   // line select
    logic [`MH_OFFSET_W-1:0] offset;  // word select
  } addr_t;

  typedef struct packed {
    logic [`MH_TAG_W-1:0]   tag;
    logic [`MH_INDEX_W-1:0] index;
  } blk_addr_t;                       // 14 bit block address into memory

  // lookup result, cache to controller
  typedef struct packed {
    logic                 hit;    // valid and tag match
    logic                 dirty;  // victim needs write-back
    logic [`MH_TAG_W-1:0] tag;    // stored tag of indexed line
    block_t               blk;    // whole indexed line
    word_t                word;   // word picked by offset
  } cache_rsp_t;

  // line write, controller to cache
  typedef struct packed {
    logic   we;     // commit at next edge
    block_t blk;    // replacement line
    logic   dirty;  // new dirty bit
  } cache_wr_t;

  typedef struct packed {
    logic      re;     // block read
    logic      we;     // block write
    blk_addr_t addr;
    block_t    wdata;  // write-back payload
  } mem_req_t;

  typedef enum logic [1:0] {
    IDLE,     // serving hits
    I_FILL,   // icache refill
    D_WBACK,  // dirty victim out
    D_FILL    // dcache refill
  } ctl_state_t;

endpackage

`default_nettype wire

// ==== hw/dm_cache.sv ====
`default_nettype none
`include "mem_hier_settings.svh"

module dm_cache
  import mem_hier_pkg::*;
(
  input  logic       clk,
  input  logic       i_arst_n,
  input  addr_t      i_addr,  // word address from cpu port
  input  cache_wr_t  i_wr,    // line write from controller
  output cache_rsp_t o_rsp    // lookup result to controller
);

  localparam int LINES = 1 << `MH_INDEX_W;  // 64 lines

  block_t               data_mem  [LINES];  // block storage
  logic [`MH_TAG_W-1:0] tag_mem   [LINES];  // stored tags
  logic                 dirty_mem [LINES];  // dirty per line
  logic [LINES-1:0]     valid_q;            // valid per line, reset

  logic [`MH_INDEX_W-1:0] idx;
  block_t                 line_blk;
  logic [`MH_TAG_W-1:0]   line_tag;
  logic                   line_vld;
  logic                   line_dirty;

  assign idx = i_addr.index;

  // read side is purely combinational from the address
  assign line_blk   = data_mem[idx];
  assign line_tag   = tag_mem[idx];
  assign line_vld   = valid_q[idx];
  assign line_dirty = dirty_mem[idx];

  always_comb begin
    o_rsp       = '0;
    o_rsp.hit   = line_vld && (line_tag == i_addr.tag);  // invalid never hits
    o_rsp.dirty = line_vld && line_dirty;   // stale dirty of empty line ignored
    o_rsp.tag   = line_tag;                 // victim tag for write-back
    o_rsp.blk   = line_blk;
    o_rsp.word  = line_blk[i_addr.offset];  // word mux
  end

  // line write, whole block at once
  always_ff @(posedge clk) begin
    if (i_wr.we) begin
      data_mem[idx]  <= i_wr.blk;
      tag_mem[idx]   <= i_addr.tag;  // tag taken from current address
      dirty_mem[idx] <= i_wr.dirty;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid_q <= '0;  // all lines empty
    end else if (i_wr.we) begin
      valid_q[idx] <= 1'b1;  // any write fills the line
    end
  end

endmodule

`default_nettype wire

// ==== hw/cache_controller.sv ====
`default_nettype none

module cache_controller
  import mem_hier_pkg::*;
(
  input  logic       clk,
  input  logic       i_arst_n,
  // cpu side
  input  addr_t      i_i_addr,    // fetch address, always live
  input  addr_t      i_d_addr,    // load/store address
  input  logic       i_re,        // load held until o_d_rdy
  input  logic       i_we,        // store held until o_d_rdy
  input  word_t      i_wrt_data,  // store word
  output logic       o_i_rdy,
  output logic       o_d_rdy,
  // caches
  input  cache_rsp_t i_i_rsp,
  input  cache_rsp_t i_d_rsp,
  output cache_wr_t  o_i_wr,
  output cache_wr_t  o_d_wr,
  // memory
  output mem_req_t   o_mem_req,
  input  logic       i_mem_done,  // one cycle pulse
  input  block_t     i_mem_rdata  // valid with done on reads
);

  ctl_state_t state_q;
  ctl_state_t state_d;

  logic   d_req;      // load or store pending
  block_t hit_merge;  // store word into hit line
  block_t fill_merge; // store word into refill block

  // drop one word into a block at the given offset
  function automatic block_t merge_word(
    input block_t                  blk,
    input logic [$bits(i_d_addr.offset)-1:0] off,
    input word_t                   w
  );
    block_t m;
    m      = blk;
    m[off] = w;
    return m;
  endfunction

  assign d_req      = i_re || i_we;
  assign hit_merge  = merge_word(i_d_rsp.blk, i_d_addr.offset, i_wrt_data);
  assign fill_merge = merge_word(i_mem_rdata, i_d_addr.offset, i_wrt_data);

  // ready only from IDLE, same cycle as the hit
  assign o_i_rdy = (state_q == IDLE) && i_i_rsp.hit;
  assign o_d_rdy = (state_q == IDLE) && d_req && i_d_rsp.hit;

  always_comb begin
    state_d   = state_q;
    o_i_wr    = '0;  // icache lines always clean
    o_d_wr    = '0;
    o_mem_req = '0;

    case (state_q)
      IDLE: begin
        // store hit goes straight into the line
        if (i_we && i_d_rsp.hit) begin
          o_d_wr.we    = 1'b1;
          o_d_wr.blk   = hit_merge;
          o_d_wr.dirty = 1'b1;
        end
        // fetch miss has priority over data miss
        if (!i_i_rsp.hit) begin
          state_d = I_FILL;
        end else if (d_req && !i_d_rsp.hit) begin
          state_d = i_d_rsp.dirty ? D_WBACK : D_FILL;
        end
      end

      I_FILL: begin
        o_mem_req.re         = !i_mem_done;  // released on done
        o_mem_req.addr.tag   = i_i_addr.tag;
        o_mem_req.addr.index = i_i_addr.index;
        if (i_mem_done) begin
          o_i_wr.we  = 1'b1;
          o_i_wr.blk = i_mem_rdata;
          state_d    = IDLE;
        end
      end

      D_WBACK: begin
        o_mem_req.we         = !i_mem_done;
        o_mem_req.addr.tag   = i_d_rsp.tag;     // victim tag
        o_mem_req.addr.index = i_d_addr.index;  // same line as request
        o_mem_req.wdata      = i_d_rsp.blk;
        if (i_mem_done) begin
          state_d = D_FILL;
        end
      end

      D_FILL: begin
        o_mem_req.re         = !i_mem_done;
        o_mem_req.addr.tag   = i_d_addr.tag;
        o_mem_req.addr.index = i_d_addr.index;
        if (i_mem_done) begin
          o_d_wr.we    = 1'b1;
          o_d_wr.blk   = i_we ? fill_merge : i_mem_rdata;  // store miss merges here
          o_d_wr.dirty = i_we;
          state_d      = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// ==== hw/unified_mem.sv ====
`default_nettype none
`include "mem_hier_settings.svh"

module unified_mem
  import mem_hier_pkg::*;
(
  input  logic     clk,
  input  logic     i_arst_n,
  input  mem_req_t i_req,    // held by controller until o_done
  output block_t   o_rdata,  // latched read block
  output logic     o_done    // one cycle pulse per transfer
);

  localparam int LAT    = `MH_MEM_LAT;
  localparam int CNT_W  = $clog2(LAT + 1);
  localparam int BLOCKS = 1 << (`MH_TAG_W + `MH_INDEX_W);  // 16384 blocks

  block_t mem [BLOCKS];

  logic [CNT_W-1:0] cnt_q;  // cycles spent on current transfer
  logic             busy;
  logic             last;

  assign busy = (i_req.re || i_req.we) && !o_done;  // ignore request during done
  assign last = busy && (cnt_q == CNT_W'(LAT - 1));

  // memory starts all zero
  initial begin
    for (int i = 0; i < BLOCKS; i++) begin
      mem[i] = '0;
    end
  end

  always @(posedge clk) begin
    if (last && i_req.we) begin
      mem[i_req.addr] <= i_req.wdata;  // write lands at end of transfer
    end
  end

  always_ff @(posedge clk) begin
    if (last && i_req.re) begin
      o_rdata <= mem[i_req.addr];  // shows up with done
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cnt_q  <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= last;
      if (last || !busy) begin
        cnt_q <= '0;  // restart for next request
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/mem_hierarchy.sv ====
`default_nettype none

module mem_hierarchy
  import mem_hier_pkg::*;
(
  input  logic  clk,
  input  logic  i_arst_n,
  // instruction port
  input  addr_t i_i_addr,
  output word_t o_instr,
  output logic  o_i_rdy,
  // data port
  input  addr_t i_d_addr,
  input  logic  i_re,
  input  logic  i_we,
  input  word_t i_wrt_data,
  output word_t o_rd_data,
  output logic  o_d_rdy
);

  cache_rsp_t icache_rsp;
  cache_rsp_t dcache_rsp;
  cache_wr_t  icache_wr;  // dirty field always low from controller
  cache_wr_t  dcache_wr;
  mem_req_t   mem_req;
  block_t     mem_rdata;
  logic       mem_done;

  dm_cache icache (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_addr   (i_i_addr),
    .i_wr     (icache_wr),
    .o_rsp    (icache_rsp)
  );

  dm_cache dcache (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_addr   (i_d_addr),
    .i_wr     (dcache_wr),
    .o_rsp    (dcache_rsp)
  );

  cache_controller cache_controller_inst (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_i_addr    (i_i_addr),
    .i_d_addr    (i_d_addr),
    .i_re        (i_re),
    .i_we        (i_we),
    .i_wrt_data  (i_wrt_data),
    .o_i_rdy     (o_i_rdy),
    .o_d_rdy     (o_d_rdy),
    .i_i_rsp     (icache_rsp),
    .i_d_rsp     (dcache_rsp),
    .o_i_wr      (icache_wr),
    .o_d_wr      (dcache_wr),
    .o_mem_req   (mem_req),
    .i_mem_done  (mem_done),
    .i_mem_rdata (mem_rdata)
  );

  unified_mem unified_mem_inst (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_req    (mem_req),
    .o_rdata  (mem_rdata),
    .o_done   (mem_done)
  );

  assign o_instr   = icache_rsp.word;  // valid while o_i_rdy
  assign o_rd_data = dcache_rsp.word;  // valid while o_d_rdy

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output logic o_clk,
  output logic o_arst_n
);

  initial begin
    o_clk = 1'b0;
    forever #50 o_clk = ~o_clk;  // period 100
  end

  initial begin
    o_arst_n = 1'b0;             // reset from time zero
    repeat (2) @(posedge o_clk); // two edges in reset
    #10;
    o_arst_n = 1'b1;             // release clear of the edge
  end

endmodule

`default_nettype wire

// ==== verification/mem_hierarchy_sva.sv ====
`default_nettype none

module mem_hierarchy_sva
  import mem_hier_pkg::*;
(
  input logic       clk,
  input logic       i_arst_n,
  input ctl_state_t i_state,     // controller state
  input logic       i_i_rdy,     // fetch ready level
  input logic       i_d_rdy,     // data ready level
  input mem_req_t   i_mem_req,   // request to backing store
  input logic       i_mem_done   // transfer done pulse
);

  int fail_cnt = 0;  // failed assertion count

  // refilled icache line hits on the held fetch address
  ifill_hit: assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_state == I_FILL) && i_mem_done |=> i_i_rdy)
  else begin
    fail_cnt++;
    $error("fetch still misses right after the icache refill");
  end

  // refilled dcache line answers the held load or store
  dfill_hit: assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_state == D_FILL) && i_mem_done |=> i_d_rdy)
  else begin
    fail_cnt++;
    $error("data access still misses right after the dcache refill");
  end

  // request held steady until the memory answers
  req_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_mem_req.re || i_mem_req.we) && !i_mem_done |=> i_mem_done || $stable(i_mem_req))
  else begin
    fail_cnt++;
    $error("memory request changed before done");
  end

endmodule

bind cache_controller mem_hierarchy_sva protocol_checks (
  .clk        (clk),
  .i_arst_n   (i_arst_n),
  .i_state    (state_q),
  .i_i_rdy    (o_i_rdy),
  .i_d_rdy    (o_d_rdy),
  .i_mem_req  (o_mem_req),
  .i_mem_done (i_mem_done)
);

`default_nettype wire

// ==== verification/mem_hierarchy_tb.sv ====
`default_nettype none

module mem_hierarchy_tb
  import mem_hier_pkg::*;
();

  localparam int TIMEOUT = 200;  // cycles per wait

  logic  clk;
  logic  arst_n;
  addr_t fetch_addr;
  addr_t data_addr;
  logic  rd_en;
  logic  wr_en;
  word_t wr_data;
  word_t instr;
  word_t rd_data;
  logic  i_rdy;
  logic  d_rdy;

  logic [15:0] lfsr_q = 16'd31107;  // seed
  word_t       ref_mem [65536];     // expected word image

  tb_clock_gen clock_gen_inst (
    .o_clk    (clk),
    .o_arst_n (arst_n)
  );

  mem_hierarchy mem_hierarchy_inst (
    .clk        (clk),
    .i_arst_n   (arst_n),
    .i_i_addr   (fetch_addr),
    .o_instr    (instr),
    .o_i_rdy    (i_rdy),
    .i_d_addr   (data_addr),
    .i_re       (rd_en),
    .i_we       (wr_en),
    .i_wrt_data (wr_data),
    .o_rd_data  (rd_data),
    .o_d_rdy    (d_rdy)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_step(lfsr_q);  // one step per bit
      v      = {v[14:0], lfsr_q[15]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input word_t exp, input word_t got);
    assert (got === exp) else begin
      $display("FAILED %s expected %h actual %h", name, exp, got);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("timeout after %0d cycles waiting for %s", TIMEOUT, what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "wait timed out");
  endtask

  // watch the bound controller checks
  always @(negedge clk) begin
    if (mem_hierarchy_inst.cache_controller_inst.protocol_checks.fail_cnt != 0) begin
      $display("protocol assertion failure seen on the controller");
      $display("TEST RESULT: FAIL");
      $fatal(1, "protocol check failed");
    end
  end

  // called and returns at posedge + 10
  task automatic data_access(input logic store, input logic [15:0] addr, input word_t wdata,
                             output word_t rdata, output int lat);
    data_addr = addr_t'(addr);
    rd_en     = !store;
    wr_en     = store;
    wr_data   = wdata;
    lat       = 0;
    @(negedge clk);                   // combinational ready settled
    while (!d_rdy) begin
      if (lat >= TIMEOUT) timeout_abort("o_d_rdy");
      lat++;
      @(negedge clk);
    end
    rdata = rd_data;
    @(posedge clk);                   // store hit lands here
    #10;
    rd_en = 1'b0;
    wr_en = 1'b0;
    if (store) ref_mem[addr] = wdata; // completed store
  endtask

  task automatic fetch(input logic [15:0] addr, output word_t word, output int lat);
    fetch_addr = addr_t'(addr);       // stays parked here afterwards
    lat        = 0;
    @(negedge clk);
    while (!i_rdy) begin
      if (lat >= TIMEOUT) timeout_abort("o_i_rdy");
      lat++;
      @(negedge clk);
    end
    word = instr;
    @(posedge clk);
    #10;
  endtask

  initial begin
    word_t       got;
    int          lat;
    int          n;
    logic [15:0] op;
    logic [15:0] sel_tag;
    logic [15:0] sel_idx;
    logic [15:0] sel_off;
    logic [15:0] addr;
    fetch_addr = addr_t'(16'hF0FC);   // tag f0 line 3f away from data traffic
    data_addr  = '0;
    rd_en      = 1'b0;
    wr_en      = 1'b0;
    wr_data    = '0;
    for (int a = 0; a < 65536; a++) begin
      ref_mem[a] = '0;                // memory starts cleared
    end
    n = 0;
    while (!arst_n) begin
      if (n >= TIMEOUT) timeout_abort("reset release");
      n++;
      @(posedge clk);
    end
    #10;

    // cold_read
    data_access(1'b0, 16'h2345, '0, got, lat);
    check_value("cold_read", ref_mem[16'h2345], got);

    // store_load_hit in the cold read block
    data_access(1'b1, 16'h2346, 16'hBEEF, got, lat);
    data_access(1'b0, 16'h2346, '0, got, lat);
    check_value("store_load_hit", ref_mem[16'h2346], got);
    check_value("store_load_hit_rdy", 16'h0000, 16'(lat));  // ready in request cycle

    // conflict_evict on line 2 with tags 55 and 66
    data_access(1'b1, 16'h5508, 16'h1357, got, lat);
    data_access(1'b1, 16'h6609, 16'h2468, got, lat);  // dirty victim written back
    data_access(1'b0, 16'h5508, '0, got, lat);
    check_value("conflict_evict", ref_mem[16'h5508], got);
    data_access(1'b0, 16'h6609, '0, got, lat);
    check_value("conflict_evict_b", ref_mem[16'h6609], got);

    // random_mix over tags 10..13 and lines 0..7
    for (int k = 0; k < 300; k++) begin
      op      = take_bits(1);
      sel_tag = take_bits(2);
      sel_idx = take_bits(3);
      sel_off = take_bits(2);
      addr    = {6'b000100, sel_tag[1:0], 3'b000, sel_idx[2:0], sel_off[1:0]};
      if (op[0]) begin
        data_access(1'b1, addr, take_bits(16), got, lat);
      end else begin
        data_access(1'b0, addr, '0, got, lat);
        check_value("random_mix", ref_mem[addr], got);
      end
    end

    // ifetch_after_evict on line 20 not yet in the icache
    data_access(1'b1, 16'h4082, take_bits(16), got, lat);
    data_access(1'b1, 16'h4181, take_bits(16), got, lat);  // pushes 4082 block to memory
    fetch(16'h4082, got, lat);
    check_value("ifetch_after_evict", ref_mem[16'h4082], got);
    fetch(16'h4083, got, lat);       // same block hits
    check_value("ifetch_after_evict_word", ref_mem[16'h4083], got);
    check_value("ifetch_after_evict_rdy", 16'h0000, 16'(lat));

    if (mem_hierarchy_inst.cache_controller_inst.protocol_checks.fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("protocol assertion failures seen on the controller");
      $display("TEST RESULT: FAIL");
      $fatal(1, "protocol check failed");
    end
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
hw/mem_hier_pkg.sv
hw/dm_cache.sv
hw/cache_controller.sv
hw/unified_mem.sv
hw/mem_hierarchy.sv
verification/tb_clock_gen.sv
verification/mem_hierarchy_sva.sv
verification/mem_hierarchy_tb.sv

// ==== Makefile ====
TOP = mem_hierarchy_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): filelist.f $(wildcard hw/*.sv verification/*.sv include/*.svh)
	verilator --binary --assert -j 0 --top-module $(TOP) -f filelist.f -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
